// File: sources.f
+incdir+include
src/useqPkg.sv
src/dispatchSelect.sv
src/skipSelect.sv
src/nextAddress.sv
src/microSequencer.sv
dv/microSequencerTb.sv

// File: Makefile
# Verilator build and run for the microcode sequencer

VERILATOR ?= verilator
FILELIST  ?= sources.f
TB_TOP    ?= microSequencerTb
RTL_TOP   ?= microSequencer
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o V$(TB_TOP)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "Simulation finished: PASS" $(LOG); then \
		echo "No pass message in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/microSequencerTb.sv
//////////////////////////////////////////////////
// Each control word is held for one cycle, then a hold word keeps addr
// Run order matters: overflow sticks, so stack limits go last
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "useq_defines.svh"

module microSequencerTb;

   // Two edges per control word, well under this limit
   localparam int TimeoutCycles = 400;

   logic                clk = 1'b0;
   logic                rstN;
   useqPkg::cromCtl_t   crom;
   useqPkg::dpWord_t    dp;
   useqPkg::dispSrc_t   dispSrc;
   useqPkg::skipConds_t skipConds;
   useqPkg::useqAddr_t  addr;
   logic                stackOverflow;

   integer seed = 11511;
   int     errors = 0;
   int     checks = 0;
   int     cycles = 0;

   // Reference state, stack front is the top
   useqPkg::useqAddr_t modelAddr;
   useqPkg::useqAddr_t modelStack [$];
   logic               modelOverflow;

   microSequencer microSequencer_i (
      .clk           (clk),
      .rstN          (rstN),
      .crom          (crom),
      .dp            (dp),
      .dispSrc       (dispSrc),
      .skipConds     (skipConds),
      .addr          (addr),
      .stackOverflow (stackOverflow)
   );

   // 8 ns clock
   always #4 clk = ~clk;

   initial
   begin
      while (cycles < TimeoutCycles)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: tests did not complete within %0d cycles", TimeoutCycles);
      $display("Simulation finished: FAIL");
      $finish;
   end

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////

   task automatic checkEq(input string name, input logic [63:0] expected,
                          input logic [63:0] actual);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("MISMATCH at %0t ns: %s expected 0x%0h, got 0x%0h",
                  $time, name, expected, actual);
      end
   endtask

   function automatic useqPkg::useqAddr_t randomAddr();
      logic [31:0] r;
      r = $random(seed);
      return r[11:0];
   endfunction

   function automatic useqPkg::dispSrc_t randomSources();
      logic [95:0] r;
      r = {$random(seed), $random(seed), $random(seed)};
      return r[$bits(useqPkg::dispSrc_t)-1:0];
   endfunction

   function automatic useqPkg::dpWord_t randomDp();
      logic [63:0] r;
      r = {$random(seed), $random(seed)};
      return r[35:0];
   endfunction

   function automatic useqPkg::skipConds_t randomConds();
      logic [31:0] r;
      r = $random(seed);
      return r[15:0];
   endfunction

   // Jump only, no dispatch, skip or stack action
   function automatic useqPkg::cromCtl_t plainWord(input useqPkg::useqAddr_t jump);
      useqPkg::cromCtl_t w;
      w = '0;
      w.jump = jump;
      return w;
   endfunction

   // Return through both halves of the return dispatch path
   function automatic useqPkg::cromCtl_t retWord();
      useqPkg::cromCtl_t w;
      w = plainWord(randomAddr());
      w.ret      = 1'b1;
      w.dispEn20 = 1'b1;
      w.dispSelH = `DISP_SELH_RET;
      w.dispEn10 = 1'b1;
      w.dispSel  = `DISP_SEL_RET;
      return w;
   endfunction

   // Dispatch bits from the enable rules, later rule wins
   function automatic useqPkg::useqAddr_t modelDispatch(input useqPkg::cromCtl_t w,
         input useqPkg::dispSrc_t s, input useqPkg::dpWord_t d,
         input useqPkg::useqAddr_t top);
      useqPkg::useqAddr_t   hiTable [4];
      useqPkg::dispNibble_t lo10 [8];
      useqPkg::dispNibble_t lo40 [8];
      useqPkg::useqAddr_t   result;
      hiTable[`DISP_SELH_DIAG]  = s.diag;
      hiTable[`DISP_SELH_RET]   = top;
      hiTable[`DISP_SELH_J]     = s.jDisp;
      hiTable[`DISP_SELH_AREAD] = s.aread;
      lo10[`DISP_SEL_DIAG]      = s.diag[3:0];
      lo10[`DISP_SEL_RET]       = top[3:0];
      lo10[`DISP_SEL_MUL]       = s.mul;
      lo10[`DISP_SEL_PF]        = s.pf;
      lo10[`DISP_SEL_NI]        = s.ni;
      lo10[`DISP_SEL_BYTE]      = s.byteDisp;
      lo10[`DISP_SEL_EA]        = s.ea;
      lo10[`DISP_SEL_SCAD]      = s.scad;
      lo40[`DISP_SEL_ZERO]      = 4'h0;
      // Big-endian bits 18..21 and 32..35
      lo40[`DISP_SEL_DP18TO21]  = d[17:14];
      lo40[`DISP_SEL_J]         = s.jDisp[3:0];
      lo40[`DISP_SEL_AREAD]     = s.aread[3:0];
      lo40[`DISP_SEL_NORM]      = s.norm;
      lo40[`DISP_SEL_DP32TO35]  = d[3:0];
      lo40[`DISP_SEL_DROMA]     = s.dromA;
      lo40[`DISP_SEL_DROMB]     = s.dromB;
      result = '0;
      if (w.dispEn20)
      begin
         result[11:4] = hiTable[w.dispSelH][11:4];
      end
      if (w.dispEn10)
      begin
         result[3:0] = lo10[w.dispSel];
      end
      if (w.dispEn40)
      begin
         result[3:0] = lo40[w.dispSel];
      end
      return result;
   endfunction

   // One control word, model update, then check after the capture edge
   task automatic runWord(input useqPkg::cromCtl_t w, input useqPkg::dispSrc_t s,
                          input useqPkg::dpWord_t d, input useqPkg::skipConds_t c);
      useqPkg::useqAddr_t top;
      useqPkg::useqAddr_t expected;
      top      = (modelStack.size() > 0) ? modelStack[0] : '0;
      expected = (w.ret ? top : w.jump) | modelDispatch(w, s, d, top);
      if ((w.skipSel != `SKIP_NONE) && c[w.skipSel])
      begin
         expected[0] = 1'b1;
      end
      // Ret beats call
      if (w.ret)
      begin
         if (modelStack.size() > 0)
         begin
            void'(modelStack.pop_front());
         end
      end
      else if (w.call)
      begin
         if (modelStack.size() == `USEQ_STACK_DEPTH)
         begin
            void'(modelStack.pop_back());
            modelOverflow = 1'b1;
         end
         modelStack.push_front(useqPkg::useqAddr_t'(modelAddr + 1));
      end
      modelAddr = expected;
      @(posedge clk);
      crom      <= w;
      dispSrc   <= s;
      dp        <= d;
      skipConds <= c;
      @(posedge clk);
      // Hold word keeps addr for the next call's push
      crom <= plainWord(expected);
      @(negedge clk);
      checkEq("addr", expected, addr);
      checkEq("stackOverflow", modelOverflow, stackOverflow);
   endtask

   //////////////////////////////////////////////////
   // Tests
   //////////////////////////////////////////////////

   task automatic testJumpSkip();
      useqPkg::cromCtl_t   w;
      useqPkg::skipConds_t c;
      for (int i = 0; i < 4; i++)
      begin
         runWord(plainWord(randomAddr()), randomSources(), randomDp(), '0);
      end
      // Odd codes see a true condition, even codes a false one
      for (int k = 1; k < 16; k++)
      begin
         w         = plainWord(randomAddr() & 12'hffe);
         w.skipSel = 4'(k);
         c         = randomConds();
         c[k]      = k[0];
         runWord(w, randomSources(), randomDp(), c);
      end
      runWord(plainWord(12'h7fe), randomSources(), randomDp(), '1);
      checkEq("addr bit 0 on SKIP_NONE", 1'b0, addr[0]);
   endtask

   task automatic testHighDispatch();
      useqPkg::cromCtl_t w;
      for (int h = 0; h < 4; h++)
      begin
         for (int n = 0; n < 2; n++)
         begin
            w          = plainWord(randomAddr());
            w.dispEn20 = 1'b1;
            w.dispSelH = 2'(h);
            runWord(w, randomSources(), randomDp(), '0);
         end
      end
   endtask

   // Group 10, group 40, then both enables
   task automatic testLowDispatch();
      useqPkg::cromCtl_t w;
      for (int g = 0; g < 3; g++)
      begin
         for (int sel = 0; sel < 8; sel++)
         begin
            w          = plainWord(randomAddr() & 12'hff0);
            w.dispEn10 = (g != 1);
            w.dispEn40 = (g != 0);
            w.dispSel  = 3'(sel);
            runWord(w, randomSources(), randomDp(), '0);
         end
      end
   endtask

   task automatic testCallReturn();
      useqPkg::cromCtl_t  w;
      useqPkg::useqAddr_t retExp [3];
      retExp = '{12'h501, 12'h401, 12'h102};
      runWord(plainWord(12'h100), randomSources(), randomDp(), '0);
      w      = plainWord(12'h300);
      w.call = 1'b1;
      runWord(w, randomSources(), randomDp(), '0);
      // Stack top 0x101 through the return dispatch path only
      w          = plainWord(12'h200);
      w.dispEn20 = 1'b1;
      w.dispSelH = `DISP_SELH_RET;
      w.dispEn10 = 1'b1;
      w.dispSel  = `DISP_SEL_RET;
      runWord(w, randomSources(), randomDp(), '0);
      runWord(retWord(), randomSources(), randomDp(), '0);
      checkEq("addr after return", 12'h101, addr);
      // Nested calls from 0x101
      for (int i = 0; i < 3; i++)
      begin
         w      = plainWord(12'h400 + 12'(i) * 12'h100);
         w.call = 1'b1;
         runWord(w, randomSources(), randomDp(), '0);
      end
      for (int i = 0; i < 3; i++)
      begin
         runWord(retWord(), randomSources(), randomDp(), '0);
         checkEq("addr after nested return", retExp[i], addr);
      end
   endtask

   task automatic testStackLimits();
      useqPkg::cromCtl_t w;
      useqPkg::dispSrc_t s;
      for (int i = 0; i < 5; i++)
      begin
         w      = plainWord(12'h700 + 12'(i) * 12'h10);
         w.call = 1'b1;
         runWord(w, randomSources(), randomDp(), '0);
      end
      checkEq("stackOverflow after five calls", 1'b1, stackOverflow);
      // Call and ret together pops only
      w      = retWord();
      w.call = 1'b1;
      runWord(w, randomSources(), randomDp(), '0);
      for (int i = 0; i < 3; i++)
      begin
         runWord(retWord(), randomSources(), randomDp(), '0);
      end
      // Empty stack, jump field ignored
      w          = plainWord(12'habc);
      w.ret      = 1'b1;
      w.dispEn40 = 1'b1;
      w.dispSel  = `DISP_SEL_J;
      w.skipSel  = 4'd3;
      s          = randomSources();
      runWord(w, s, randomDp(), 16'h0008);
      checkEq("addr on empty return", {8'h00, s.jDisp[3:0]} | 12'h001, addr);
      w     = plainWord(12'habc);
      w.ret = 1'b1;
      runWord(w, randomSources(), randomDp(), '0);
      checkEq("addr on bare empty return", 12'h000, addr);
   endtask

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////

   initial
   begin
      rstN          = 1'b0;
      crom          = '0;
      dp            = '0;
      dispSrc       = '0;
      skipConds     = '0;
      modelAddr     = '0;
      modelOverflow = 1'b0;
      repeat (4) @(posedge clk);
      rstN <= 1'b1;
      @(negedge clk);
      checkEq("addr after reset", 12'h000, addr);
      checkEq("stackOverflow after reset", 1'b0, stackOverflow);
      testJumpSkip();
      testHighDispatch();
      testLowDispatch();
      testCallReturn();
      testStackLimits();
      @(posedge clk);
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
      begin
         $display("Simulation finished: PASS");
      end
      else
      begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

// File: src/microSequencer.sv
//////////////////////////////////////////////////
// No handshake, a new control word every clock
// addr follows the inputs one edge later
//////////////////////////////////////////////////

`timescale 1ns/1ns

module microSequencer (
   input  logic                clk,
   input  logic                rstN,
   input  useqPkg::cromCtl_t   crom,
   input  useqPkg::dpWord_t    dp,
   input  useqPkg::dispSrc_t   dispSrc,
   input  useqPkg::skipConds_t skipConds,
   output useqPkg::useqAddr_t  addr,
   output logic                stackOverflow
);

   // Dispatch bits to OR into the jump field
   useqPkg::useqAddr_t dispAddr;

   // Selected skip condition
   logic               skipBit;

   // Stack top, also the return dispatch source
   useqPkg::useqAddr_t retAddr;

   //////////////////////////////////////////////////
   // Address sources
   //////////////////////////////////////////////////

   dispatchSelect dispatchSelect_i (
      .crom     (crom),
      .dp       (dp),
      .dispSrc  (dispSrc),
      .retAddr  (retAddr),
      .dispAddr (dispAddr)
   );

   skipSelect skipSelect_i (
      .skipSel   (crom.skipSel),
      .skipConds (skipConds),
      .skipBit   (skipBit)
   );

   //////////////////////////////////////////////////
   // Address register and return stack
   //////////////////////////////////////////////////

   nextAddress nextAddress_i (
      .clk           (clk),
      .rstN          (rstN),
      .crom          (crom),
      .dispAddr      (dispAddr),
      .skipBit       (skipBit),
      .addr          (addr),
      .retAddr       (retAddr),
      .stackOverflow (stackOverflow)
   );

endmodule

// File: src/nextAddress.sv
//////////////////////////////////////////////////
// Full stack push drops the oldest entry
// Empty stack pops as zero, overflow flag sticks
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "useq_defines.svh"

module nextAddress (
   input  logic               clk,
   input  logic               rstN,
   input  useqPkg::cromCtl_t  crom,
   input  useqPkg::useqAddr_t dispAddr,
   input  logic               skipBit,
   output useqPkg::useqAddr_t addr,
   output useqPkg::useqAddr_t retAddr,
   output logic               stackOverflow
);

   // Room for counts 0 through depth
   localparam int DepthW = $clog2(`USEQ_STACK_DEPTH + 1);

   // Entry 0 is the top of stack
   useqPkg::useqAddr_t stack [`USEQ_STACK_DEPTH];

   // Number of valid entries
   logic [DepthW-1:0]  depth;

   logic               stackFull;
   logic               push;
   logic               pop;
   useqPkg::useqAddr_t baseAddr;
   useqPkg::useqAddr_t nextAddr;

   //////////////////////////////////////////////////
   // Next address forming
   //////////////////////////////////////////////////

   // Ret has priority, a combined call is ignored
   assign pop       = crom.ret;
   assign push      = crom.call & ~crom.ret;
   assign stackFull = (depth == DepthW'(`USEQ_STACK_DEPTH));

   // Stack top, zero when nothing is pushed
   assign retAddr = (depth != '0) ? stack[0] : '0;

   // Return replaces the jump field
   assign baseAddr = pop ? retAddr : crom.jump;

   // Dispatch and skip can only set bits
   always_comb
   begin
      nextAddr    = baseAddr | dispAddr;
      nextAddr[0] = nextAddr[0] | skipBit;
   end

   //////////////////////////////////////////////////
   // Address register
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         addr <= '0;
      end
      else
      begin
         addr <= nextAddr;
      end
   end

   //////////////////////////////////////////////////
   // Return stack
   //////////////////////////////////////////////////

   // Entries shift down on push, up on pop
   always_ff @(posedge clk)
   begin
      if (push)
      begin
         // Bottom entry falls off when full
         for (int i = `USEQ_STACK_DEPTH - 1; i > 0; i--)
         begin
            stack[i] <= stack[i-1];
         end
         stack[0] <= addr + `USEQ_ADDR_W'(1);
      end
      else if (pop)
      begin
         for (int i = 0; i < `USEQ_STACK_DEPTH - 1; i++)
         begin
            stack[i] <= stack[i+1];
         end
      end
   end

   // Depth count and sticky overflow
   always_ff @(posedge clk or negedge rstN)
   begin
      if (!rstN)
      begin
         depth         <= '0;
         stackOverflow <= 1'b0;
      end
      else
      begin
         if (push)
         begin
            if (stackFull)
            begin
               // Depth saturates
               stackOverflow <= 1'b1;
            end
            else
            begin
               depth <= depth + DepthW'(1);
            end
         end
         else if (pop && (depth != '0))
         begin
            depth <= depth - DepthW'(1);
         end
      end
   end

endmodule

// File: src/skipSelect.sv
//////////////////////////////////////////////////
// Combinational, skip only ever sets address bit 0
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "useq_defines.svh"

module skipSelect (
   input  logic [3:0]          skipSel,
   input  useqPkg::skipConds_t skipConds,
   output logic                skipBit
);

   //////////////////////////////////////////////////
   // Skip condition select
   //////////////////////////////////////////////////

   // Raw indexed condition
   logic condBit;

   // Codes 1 to 15 pick the matching flag
   // Flag 0 has no meaning and is masked below
   assign condBit = skipConds[skipSel];

   // Never skip on the idle code
   always_comb
   begin
      if (skipSel == `SKIP_NONE)
      begin
         skipBit = 1'b0;
      end
      else
      begin
         skipBit = condBit;
      end
   end

endmodule

// File: src/dispatchSelect.sv
//////////////////////////////////////////////////
// Purely combinational, result can only set bits
// Enable 40 overrides enable 10 on the low nibble
//////////////////////////////////////////////////

`timescale 1ns/1ns

`include "useq_defines.svh"

module dispatchSelect (
   input  useqPkg::cromCtl_t  crom,
   input  useqPkg::dpWord_t   dp,
   input  useqPkg::dispSrc_t  dispSrc,
   input  useqPkg::useqAddr_t retAddr,
   output useqPkg::useqAddr_t dispAddr
);

   //////////////////////////////////////////////////
   // N-way dispatch multiplexer
   //////////////////////////////////////////////////

   always_comb
   begin
      // Nothing selected, no bits set
      dispAddr = '0;

      // High bits 11..4
      if (crom.dispEn20)
      begin
         case (crom.dispSelH)
            `DISP_SELH_DIAG:
               dispAddr[11:4] = dispSrc.diag[11:4];
            `DISP_SELH_RET:
               dispAddr[11:4] = retAddr[11:4];
            `DISP_SELH_J:
               dispAddr[11:4] = dispSrc.jDisp[11:4];
            `DISP_SELH_AREAD:
               dispAddr[11:4] = dispSrc.aread[11:4];
         endcase
      end

      // Low bits 3..0, group 10
      if (crom.dispEn10)
      begin
         case (crom.dispSel)
            `DISP_SEL_DIAG:
               dispAddr[3:0] = dispSrc.diag[3:0];
            `DISP_SEL_RET:
               dispAddr[3:0] = retAddr[3:0];
            `DISP_SEL_MUL:
               dispAddr[3:0] = dispSrc.mul;
            `DISP_SEL_PF:
               dispAddr[3:0] = dispSrc.pf;
            `DISP_SEL_NI:
               dispAddr[3:0] = dispSrc.ni;
            `DISP_SEL_BYTE:
               dispAddr[3:0] = dispSrc.byteDisp;
            `DISP_SEL_EA:
               dispAddr[3:0] = dispSrc.ea;
            `DISP_SEL_SCAD:
               dispAddr[3:0] = dispSrc.scad;
         endcase
      end

      // Low bits 3..0, group 40
      // Evaluated last so it wins over group 10
      if (crom.dispEn40)
      begin
         case (crom.dispSel)
            `DISP_SEL_ZERO:
               dispAddr[3:0] = 4'b0000;
            // Big-endian dp 18..21
            `DISP_SEL_DP18TO21:
               dispAddr[3:0] = dp[17:14];
            `DISP_SEL_J:
               dispAddr[3:0] = dispSrc.jDisp[3:0];
            `DISP_SEL_AREAD:
               dispAddr[3:0] = dispSrc.aread[3:0];
            `DISP_SEL_NORM:
               dispAddr[3:0] = dispSrc.norm;
            // Big-endian dp 32..35
            `DISP_SEL_DP32TO35:
               dispAddr[3:0] = dp[3:0];
            `DISP_SEL_DROMA:
               dispAddr[3:0] = dispSrc.dromA;
            `DISP_SEL_DROMB:
               dispAddr[3:0] = dispSrc.dromB;
         endcase
      end
   end

endmodule

// File: src/useqPkg.sv
//////////////////////////////////////////////////
// Only the sequencer fields of the control word
// Return dispatch source comes from the stack
//////////////////////////////////////////////////

`include "useq_defines.svh"

package useqPkg;

   // Microcode address
   typedef logic [`USEQ_ADDR_W-1:0] useqAddr_t;

   // Low dispatch value, address bits 3..0
   typedef logic [3:0] dispNibble_t;

   // Datapath word, bit 35 is MSB
   typedef logic [35:0] dpWord_t;

   // Skip conditions
   // Bit 0 is never selected
   typedef logic [15:0] skipConds_t;

   // Sequencer fields of the control ROM word
   typedef struct packed {
      useqAddr_t   jump;
      logic        dispEn10;
      logic        dispEn20;
      logic        dispEn40;
      logic [1:0]  dispSelH;
      logic [2:0]  dispSel;
      logic [3:0]  skipSel;
      logic        call;
      logic        ret;
   } cromCtl_t;

   // External dispatch sources
   typedef struct packed {
      // Full width sources
      useqAddr_t   diag;
      useqAddr_t   jDisp;
      useqAddr_t   aread;
      // Low nibble sources
      dispNibble_t mul;
      dispNibble_t pf;
      dispNibble_t ni;
      dispNibble_t byteDisp;
      dispNibble_t ea;
      dispNibble_t scad;
      dispNibble_t norm;
      dispNibble_t dromA;
      dispNibble_t dromB;
   } dispSrc_t;

endpackage

// File: include/useq_defines.svh
//////////////////////////////////////////////////
// Select codes follow the control ROM encoding
// Address bits are little-endian, bit 11 is MSB
//////////////////////////////////////////////////

`ifndef USEQ_DEFINES_SVH
`define USEQ_DEFINES_SVH

// Microcode address width
`define USEQ_ADDR_W       12

// Return stack entries
`define USEQ_STACK_DEPTH  4

// High dispatch select, address bits 11..4
`define DISP_SELH_DIAG    2'd0
`define DISP_SELH_RET     2'd1
`define DISP_SELH_J       2'd2
`define DISP_SELH_AREAD   2'd3

// Low dispatch select with enable 10
`define DISP_SEL_DIAG     3'd0
`define DISP_SEL_RET      3'd1
`define DISP_SEL_MUL      3'd2
`define DISP_SEL_PF       3'd3
`define DISP_SEL_NI       3'd4
`define DISP_SEL_BYTE     3'd5
`define DISP_SEL_EA       3'd6
`define DISP_SEL_SCAD     3'd7

// Low dispatch select with enable 40
`define DISP_SEL_ZERO     3'd0
`define DISP_SEL_DP18TO21 3'd1
`define DISP_SEL_J        3'd2
`define DISP_SEL_AREAD    3'd3
`define DISP_SEL_NORM     3'd4
`define DISP_SEL_DP32TO35 3'd5
`define DISP_SEL_DROMA    3'd6
`define DISP_SEL_DROMB    3'd7

// Skip code that never skips
`define SKIP_NONE         4'd0

`endif
